/* gpio_bus_pkg.sv */
// AXI4-Lite bus definitions

package gpio_bus_pkg;

	// ----------------------------------------
	// channel widths
	// ----------------------------------------
	localparam int unsigned axil_addr_width = 8;
	localparam int unsigned axil_data_width = 32;
	localparam int unsigned axil_strb_width = axil_data_width / 8;

	// byte address, only the low 8 bits are decoded
	typedef logic [axil_addr_width-1:0] axil_addr_t;

	// one bus word
	typedef logic [axil_data_width-1:0] axil_data_t;

	// one strobe per byte lane
	typedef logic [axil_strb_width-1:0] axil_strb_t;

	// ----------------------------------------
	// response codes
	// ----------------------------------------
	// EXOKAY and DECERR are never returned by this slave
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} axil_resp_t;

endpackage

/* gpio_reg_pkg.sv */
// GPIO register map

package gpio_reg_pkg;

	// ----------------------------------------
	// word offsets
	// ----------------------------------------
	localparam logic [7:0] reg_ofs_direction  = 8'h00;
	localparam logic [7:0] reg_ofs_input      = 8'h04;
	localparam logic [7:0] reg_ofs_output     = 8'h08;
	localparam logic [7:0] reg_ofs_irq_enable = 8'h0C;
	localparam logic [7:0] reg_ofs_irq_status = 8'h10;

	// register picked by one request
	typedef enum logic [2:0] {
		sel_direction,
		sel_input,
		sel_output,
		sel_irq_enable,
		sel_irq_status,
		sel_none
	} reg_sel_e;

	// unaligned or unmapped addresses fall through to sel_none
	function automatic reg_sel_e addr_to_sel(input logic [7:0] addr);
		case (addr)
			reg_ofs_direction:  return sel_direction;
			reg_ofs_input:      return sel_input;
			reg_ofs_output:     return sel_output;
			reg_ofs_irq_enable: return sel_irq_enable;
			reg_ofs_irq_status: return sel_irq_status;
			default:            return sel_none;
		endcase
	endfunction

endpackage

/* gpio_if.sv */
// GPIO stage interfaces

`timescale 1ns/1ps

// ----------------------------------------
// decode to execute
// ----------------------------------------
interface gpio_req_if;
	import gpio_bus_pkg::*;
	import gpio_reg_pkg::*;

	logic       valid;
	logic       write;
	reg_sel_e   sel;
	axil_data_t wdata;
	axil_strb_t wstrb;
	logic       ready;

	modport master (
		output valid, write, sel, wdata, wstrb,
		input  ready
	);

	modport slave (
		input  valid, write, sel, wdata, wstrb,
		output ready
	);
endinterface

// ----------------------------------------
// execute to result
// ----------------------------------------
interface gpio_rsp_if;
	import gpio_bus_pkg::*;

	logic       valid;
	logic       write;
	axil_data_t rdata;
	axil_resp_t resp;
	logic       ready;

	modport master (
		output valid, write, rdata, resp,
		input  ready
	);

	modport slave (
		input  valid, write, rdata, resp,
		output ready
	);
endinterface

/* gpio_axil_decode.sv */
// AXI4-Lite request decode

`timescale 1ns/1ps

module gpio_axil_decode (
	input  logic                    clk,
	input  logic                    reset,

	// write address and data
	input  gpio_bus_pkg::axil_addr_t awaddr_i,
	input  logic                    awvalid_i,
	output logic                    awready_o,
	input  gpio_bus_pkg::axil_data_t wdata_i,
	input  gpio_bus_pkg::axil_strb_t wstrb_i,
	input  logic                    wvalid_i,
	output logic                    wready_o,

	// read address
	input  gpio_bus_pkg::axil_addr_t araddr_i,
	input  logic                    arvalid_i,
	output logic                    arready_o,

	gpio_req_if.master              req
);
	import gpio_bus_pkg::*;
	import gpio_reg_pkg::*;

	// one request slot
	logic       slot_valid;
	logic       slot_write;
	reg_sel_e   slot_sel;
	axil_data_t slot_wdata;
	axil_strb_t slot_wstrb;

	logic       wr_take;
	logic       rd_take;

	// ----------------------------------------
	// bus handshake
	// ----------------------------------------
	// address and data only go together, so no half-taken write
	assign wr_take = ~slot_valid & awvalid_i & wvalid_i;

	// writes win, a read waits while either write channel is offered
	assign rd_take = ~slot_valid & arvalid_i & ~awvalid_i & ~wvalid_i;

	assign awready_o = wr_take;
	assign wready_o  = wr_take;
	assign arready_o = rd_take;

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_valid <= 1'b0;
		end else if (wr_take | rd_take) begin
			slot_valid <= 1'b1;
		end else if (req.ready) begin
			slot_valid <= 1'b0;
		end
	end

	// ----------------------------------------
	// capture and address decode
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (wr_take) begin
			slot_write <= 1'b1;
			slot_sel   <= addr_to_sel(awaddr_i);
			slot_wdata <= wdata_i;
			slot_wstrb <= wstrb_i;
		end else if (rd_take) begin
			slot_write <= 1'b0;
			slot_sel   <= addr_to_sel(araddr_i);
			slot_wdata <= '0;
			slot_wstrb <= '0;
		end
	end

	// request to execute
	assign req.valid = slot_valid;
	assign req.write = slot_write;
	assign req.sel   = slot_sel;
	assign req.wdata = slot_wdata;
	assign req.wstrb = slot_wstrb;

endmodule

/* gpio_port_exec.sv */
// GPIO registers and port logic

`timescale 1ns/1ps

module gpio_port_exec #(
	parameter int                    PORT_WIDTH     = 8,
	parameter logic [PORT_WIDTH-1:0] INIT_DIRECTION = '0,
	parameter logic [PORT_WIDTH-1:0] INIT_OUTPUT    = '0,
	parameter logic [PORT_WIDTH-1:0] DIRECTION_MASK = '0
) (
	input  logic                  clk,
	input  logic                  reset,
	gpio_req_if.slave             req,
	gpio_rsp_if.master            rsp,
	input  logic [PORT_WIDTH-1:0] port_i,
	output logic [PORT_WIDTH-1:0] port_o,
	output logic [PORT_WIDTH-1:0] port_t,
	output logic                  irq_o
);
	import gpio_bus_pkg::*;
	import gpio_reg_pkg::*;

	logic [PORT_WIDTH-1:0] dir_q, out_q, irq_en_q, irq_sts_q;
	logic [PORT_WIDTH-1:0] sync_meta, in_q, in_d;
	logic [PORT_WIDTH-1:0] rise, sts_clr, rd_val;
	axil_data_t            rd_word, wr_word, clr_word;
	logic                  accept, do_write, bad_access, irq_q, rsp_valid;

	// zero-extend a pin vector to a bus word
	function automatic axil_data_t pad_port(input logic [PORT_WIDTH-1:0] val);
		axil_data_t word;
		word = '0;
		word[PORT_WIDTH-1:0] = val;
		return word;
	endfunction

	// bytes with a strobe take the new data
	function automatic axil_data_t merge_strb(input axil_data_t old_w, input axil_data_t new_w,
		input axil_strb_t strb);
		axil_data_t word;
		word = old_w;
		for (int b = 0; b < $bits(axil_strb_t); b++) begin
			if (strb[b])
				word[8*b +: 8] = new_w[8*b +: 8];
		end
		return word;
	endfunction

	// ----------------------------------------
	// request handling
	// ----------------------------------------
	assign req.ready  = ~rsp_valid | rsp.ready;
	assign accept     = req.valid & req.ready;
	assign do_write   = accept & req.write;
	assign bad_access = (req.sel == sel_none) | (req.write & (req.sel == sel_input));

	always_comb begin
		case (req.sel)
			sel_direction:  rd_val = dir_q;
			sel_input:      rd_val = in_q;
			sel_output:     rd_val = out_q;
			sel_irq_enable: rd_val = irq_en_q;
			sel_irq_status: rd_val = irq_sts_q;
			default:        rd_val = '0;
		endcase
		rd_word  = pad_port(rd_val);
		wr_word  = merge_strb(rd_word, req.wdata, req.wstrb);
		clr_word = merge_strb('0, req.wdata, req.wstrb);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dir_q    <= INIT_DIRECTION;
			out_q    <= INIT_OUTPUT;
			irq_en_q <= '0;
		end else if (do_write) begin
			case (req.sel)
				// locked pins keep their reset direction
				sel_direction:  dir_q <= (dir_q & DIRECTION_MASK) |
					(wr_word[PORT_WIDTH-1:0] & ~DIRECTION_MASK);
				sel_output:     out_q <= wr_word[PORT_WIDTH-1:0];
				sel_irq_enable: irq_en_q <= wr_word[PORT_WIDTH-1:0];
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// input sync and edge interrupt
	// ----------------------------------------
	assign rise    = in_q & ~in_d;
	assign sts_clr = (do_write && req.sel == sel_irq_status) ? clr_word[PORT_WIDTH-1:0] : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_meta <= '0;
			in_q      <= '0;
			in_d      <= '0;
			irq_sts_q <= '0;
			irq_q     <= 1'b0;
		end else begin
			sync_meta <= port_i;
			in_q      <= sync_meta;
			in_d      <= in_q;
			// a fresh edge beats a write-one clear
			irq_sts_q <= (irq_sts_q & ~sts_clr) | rise;
			irq_q     <= |(irq_sts_q & irq_en_q);
		end
	end

	// ----------------------------------------
	// response slot
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
		end else if (accept) begin
			rsp_valid <= 1'b1;
		end else if (rsp.ready) begin
			rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rsp.write <= req.write;
			rsp.rdata <= req.write ? '0 : rd_word;
			rsp.resp  <= bad_access ? resp_slverr : resp_okay;
		end
	end

	assign rsp.valid = rsp_valid;
	assign port_o    = out_q;
	// direction 1 drives the pin, port_t 1 floats it
	assign port_t    = ~dir_q;
	assign irq_o     = irq_q;

endmodule

/* gpio_axil_result.sv */
// AXI4-Lite response channels

`timescale 1ns/1ps

module gpio_axil_result (
	input  logic                     clk,
	input  logic                     reset,
	gpio_rsp_if.slave                rsp,

	// write response
	output gpio_bus_pkg::axil_resp_t bresp_o,
	output logic                     bvalid_o,
	input  logic                     bready_i,

	// read data
	output gpio_bus_pkg::axil_data_t rdata_o,
	output gpio_bus_pkg::axil_resp_t rresp_o,
	output logic                     rvalid_o,
	input  logic                     rready_i
);
	import gpio_bus_pkg::*;

	logic       res_valid;
	logic       res_write;
	axil_data_t res_rdata;
	axil_resp_t res_resp;
	logic       take;
	logic       done;

	// ----------------------------------------
	// slot control
	// ----------------------------------------
	// only an empty slot takes a new response
	assign rsp.ready = ~res_valid;
	assign take      = rsp.valid & ~res_valid;
	assign done      = (bvalid_o & bready_i) | (rvalid_o & rready_i);

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
		end else if (take) begin
			res_valid <= 1'b1;
		end else if (done) begin
			res_valid <= 1'b0;
		end
	end

	// payload held steady until the master takes it
	always_ff @(posedge clk) begin
		if (take) begin
			res_write <= rsp.write;
			res_rdata <= rsp.rdata;
			res_resp  <= rsp.resp;
		end
	end

	// ----------------------------------------
	// channel routing
	// ----------------------------------------
	assign bvalid_o = res_valid & res_write;
	assign bresp_o  = res_resp;

	assign rvalid_o = res_valid & ~res_write;
	assign rresp_o  = res_resp;
	assign rdata_o  = res_rdata;

endmodule

/* gpio_subsystem.sv */
// GPIO peripheral top level

`timescale 1ns/1ps

module gpio_subsystem #(
	parameter int                    PORT_WIDTH     = 8,
	parameter logic [PORT_WIDTH-1:0] INIT_DIRECTION = '0,
	parameter logic [PORT_WIDTH-1:0] INIT_OUTPUT    = '0,
	parameter logic [PORT_WIDTH-1:0] DIRECTION_MASK = '0
) (
	input  logic                     clk,
	input  logic                     reset,

	// AXI4-Lite write channels
	input  gpio_bus_pkg::axil_addr_t awaddr_i,
	input  logic                     awvalid_i,
	output logic                     awready_o,
	input  gpio_bus_pkg::axil_data_t wdata_i,
	input  gpio_bus_pkg::axil_strb_t wstrb_i,
	input  logic                     wvalid_i,
	output logic                     wready_o,
	output gpio_bus_pkg::axil_resp_t bresp_o,
	output logic                     bvalid_o,
	input  logic                     bready_i,

	// AXI4-Lite read channels
	input  gpio_bus_pkg::axil_addr_t araddr_i,
	input  logic                     arvalid_i,
	output logic                     arready_o,
	output gpio_bus_pkg::axil_data_t rdata_o,
	output gpio_bus_pkg::axil_resp_t rresp_o,
	output logic                     rvalid_o,
	input  logic                     rready_i,

	// pins
	input  logic [PORT_WIDTH-1:0]    port_i,
	output logic [PORT_WIDTH-1:0]    port_o,
	output logic [PORT_WIDTH-1:0]    port_t,
	output logic                     irq_o
);

	gpio_req_if req_bus ();
	gpio_rsp_if rsp_bus ();

	// ----------------------------------------
	// decode, execute, result
	// ----------------------------------------
	gpio_axil_decode u_decode (
		.clk       (clk),
		.reset     (reset),
		.awaddr_i  (awaddr_i),
		.awvalid_i (awvalid_i),
		.awready_o (awready_o),
		.wdata_i   (wdata_i),
		.wstrb_i   (wstrb_i),
		.wvalid_i  (wvalid_i),
		.wready_o  (wready_o),
		.araddr_i  (araddr_i),
		.arvalid_i (arvalid_i),
		.arready_o (arready_o),
		.req       (req_bus.master)
	);

	gpio_port_exec #(
		.PORT_WIDTH     (PORT_WIDTH),
		.INIT_DIRECTION (INIT_DIRECTION),
		.INIT_OUTPUT    (INIT_OUTPUT),
		.DIRECTION_MASK (DIRECTION_MASK)
	) u_exec (
		.clk    (clk),
		.reset  (reset),
		.req    (req_bus.slave),
		.rsp    (rsp_bus.master),
		.port_i (port_i),
		.port_o (port_o),
		.port_t (port_t),
		.irq_o  (irq_o)
	);

	gpio_axil_result u_result (
		.clk      (clk),
		.reset    (reset),
		.rsp      (rsp_bus.slave),
		.bresp_o  (bresp_o),
		.bvalid_o (bvalid_o),
		.bready_i (bready_i),
		.rdata_o  (rdata_o),
		.rresp_o  (rresp_o),
		.rvalid_o (rvalid_o),
		.rready_i (rready_i)
	);

endmodule

/* gpio_tb_chk.sv */
// GPIO bus and port assertions

`timescale 1ns/1ps

module gpio_tb_chk #(
	parameter int                    PORT_WIDTH     = 8,
	parameter logic [PORT_WIDTH-1:0] INIT_DIRECTION = '0,
	parameter logic [PORT_WIDTH-1:0] DIRECTION_MASK = '0
) (
	input logic                     clk,
	input logic                     reset,
	input logic                     awready_o,
	input logic                     wready_o,
	input gpio_bus_pkg::axil_resp_t bresp_o,
	input logic                     bvalid_o,
	input logic                     bready_i,
	input gpio_bus_pkg::axil_data_t rdata_o,
	input gpio_bus_pkg::axil_resp_t rresp_o,
	input logic                     rvalid_o,
	input logic                     rready_i,
	input logic [PORT_WIDTH-1:0]    port_t
);

	// ----------------------------------------
	// response channels
	// ----------------------------------------
	b_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
		else $error("bvalid_o dropped or bresp_o changed before bready_i");

	r_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rresp_o) && $stable(rdata_o))
		else $error("rvalid_o dropped or read payload changed before rready_i");

	// address and data always taken together
	aw_w_pair: assert property (@(posedge clk) disable iff (reset)
		awready_o == wready_o)
		else $error("awready_o and wready_o differ");

	// locked pins keep their reset direction
	dir_lock: assert property (@(posedge clk) disable iff (reset)
		(port_t & DIRECTION_MASK) == (~INIT_DIRECTION & DIRECTION_MASK))
		else $error("a locked port_t bit left its reset value");

endmodule

bind gpio_subsystem gpio_tb_chk #(
	.PORT_WIDTH     (PORT_WIDTH),
	.INIT_DIRECTION (INIT_DIRECTION),
	.DIRECTION_MASK (DIRECTION_MASK)
) u_chk (
	.clk       (clk),
	.reset     (reset),
	.awready_o (awready_o),
	.wready_o  (wready_o),
	.bresp_o   (bresp_o),
	.bvalid_o  (bvalid_o),
	.bready_i  (bready_i),
	.rdata_o   (rdata_o),
	.rresp_o   (rresp_o),
	.rvalid_o  (rvalid_o),
	.rready_i  (rready_i),
	.port_t    (port_t)
);

/* gpio_tb.sv */
// GPIO peripheral testbench

`timescale 1ns/1ps

module gpio_tb;
	import gpio_bus_pkg::*;

	localparam int TIMEOUT_CYCLES = 100;

	logic       clk;
	logic       reset;
	axil_addr_t awaddr;
	logic       awvalid;
	logic       awready;
	axil_data_t wdata;
	axil_strb_t wstrb;
	logic       wvalid;
	logic       wready;
	axil_resp_t bresp;
	logic       bvalid;
	logic       bready;
	axil_addr_t araddr;
	logic       arvalid;
	logic       arready;
	axil_data_t rdata;
	axil_resp_t rresp;
	logic       rvalid;
	logic       rready;
	logic [7:0] port_i;
	logic [7:0] port_o;
	logic [7:0] port_t;
	logic       irq;

	int errors_in_test;
	int tests_passed;
	int tests_failed;
	bit timed_out;

	gpio_subsystem #(
		.PORT_WIDTH     (8),
		.INIT_DIRECTION (8'h0F),
		.INIT_OUTPUT    (8'hA5),
		.DIRECTION_MASK (8'h81)
	) UUT (
		.clk       (clk),
		.reset     (reset),
		.awaddr_i  (awaddr),
		.awvalid_i (awvalid),
		.awready_o (awready),
		.wdata_i   (wdata),
		.wstrb_i   (wstrb),
		.wvalid_i  (wvalid),
		.wready_o  (wready),
		.bresp_o   (bresp),
		.bvalid_o  (bvalid),
		.bready_i  (bready),
		.araddr_i  (araddr),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.rdata_o   (rdata),
		.rresp_o   (rresp),
		.rvalid_o  (rvalid),
		.rready_i  (rready),
		.port_i    (port_i),
		.port_o    (port_o),
		.port_t    (port_t),
		.irq_o     (irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected 0x%0h, actual 0x%0h", $time, name, expected,
				actual);
			errors_in_test++;
		end
	endtask

	task automatic report_timeout(input string channel);
		$display("Timeout: the %s channel never answered within %0d cycles", channel,
			TIMEOUT_CYCLES);
		errors_in_test++;
		timed_out = 1'b1;
	endtask

	// ----------------------------------------
	// bus master
	// ----------------------------------------
	task automatic bus_write(input axil_addr_t addr, input axil_data_t data,
		input axil_strb_t strb, output logic [1:0] resp);
		int   cycles;
		logic taken;
		resp = 'x;
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= strb;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			taken = awready & wready;
		end while (!taken && cycles < TIMEOUT_CYCLES);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		if (!taken) begin
			report_timeout("AW/W");
		end else begin
			// master stalls the B channel for a while
			repeat ($urandom_range(5, 0)) @(posedge clk);
			bready <= 1'b1;
			cycles = 0;
			do begin
				@(posedge clk);
				cycles++;
				taken = bvalid;
			end while (!taken && cycles < TIMEOUT_CYCLES);
			bready <= 1'b0;
			if (taken)
				resp = bresp;
			else
				report_timeout("B");
		end
	endtask

	task automatic bus_read(input axil_addr_t addr, output axil_data_t data,
		output logic [1:0] resp);
		int   cycles;
		logic taken;
		data = 'x;
		resp = 'x;
		araddr  <= addr;
		arvalid <= 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			taken = arready;
		end while (!taken && cycles < TIMEOUT_CYCLES);
		arvalid <= 1'b0;
		if (!taken) begin
			report_timeout("AR");
		end else begin
			repeat ($urandom_range(5, 0)) @(posedge clk);
			rready <= 1'b1;
			cycles = 0;
			do begin
				@(posedge clk);
				cycles++;
				taken = rvalid;
			end while (!taken && cycles < TIMEOUT_CYCLES);
			rready <= 1'b0;
			if (taken) begin
				data = rdata;
				resp = rresp;
			end else begin
				report_timeout("R");
			end
		end
	endtask

	// ----------------------------------------
	// one stimulus line
	// ----------------------------------------
	task automatic run_step(input int op, input axil_addr_t addr, input axil_data_t data,
		input axil_strb_t strb, input axil_data_t exp_rdata, input logic [1:0] exp_resp);
		axil_data_t got_data;
		logic [1:0] got_resp;
		int         tries;
		case (op)
			0: begin
				bus_write(addr, data, strb, got_resp);
				if (!timed_out)
					check_value("bresp_o", exp_resp, got_resp);
			end
			1, 3: begin
				// op 3 retries while the synchroniser catches up
				tries = 0;
				do begin
					bus_read(addr, got_data, got_resp);
					tries++;
				end while (op == 3 && !timed_out && got_data !== exp_rdata &&
					tries < TIMEOUT_CYCLES);
				if (!timed_out) begin
					check_value("rdata_o", exp_rdata, got_data);
					check_value("rresp_o", exp_resp, got_resp);
				end
			end
			2: begin
				port_i <= data[7:0];
				@(posedge clk);
			end
			default: begin
				$display("The stimulus file holds an unknown operation %0d", op);
				errors_in_test++;
			end
		endcase
	endtask

	// pins sampled away from the active edge
	task automatic check_pins(input logic [7:0] exp_po, input logic [7:0] exp_pt,
		input logic exp_irq);
		@(negedge clk);
		check_value("port_o", exp_po, port_o);
		check_value("port_t", exp_pt, port_t);
		check_value("irq_o", exp_irq, irq);
		@(posedge clk);
	endtask

	task automatic close_test(input int num);
		if (errors_in_test == 0) begin
			$display("test %0d passed", num);
			tests_passed++;
		end else begin
			$display("test %0d failed with %0d errors", num, errors_in_test);
			tests_failed++;
		end
		errors_in_test = 0;
	endtask

	initial begin
		int               fd;
		int               n;
		int               seed;
		int               test_num;
		int               cur_test;
		int               op;
		int               port_chk;
		logic [31:0]      addr, data, strb, exp_rdata, exp_resp;
		logic [31:0]      exp_po, exp_pt, exp_irq;
		logic [8*200-1:0] line;

		reset   = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		port_i  = '0;
		errors_in_test = 0;
		tests_passed   = 0;
		tests_failed   = 0;
		timed_out      = 1'b0;
		seed = $urandom(14);

		fd = $fopen("gpio_input.txt", "r");
		if (fd == 0) begin
			$display("The stimulus file gpio_input.txt could not be opened");
			tests_failed++;
		end else begin
			repeat (3) @(posedge clk);
			reset <= 1'b0;
			cur_test = -1;
			while (!$feof(fd) && !timed_out) begin
				line = '0;
				n = $fgets(line, fd);
				// comment lines fail the scan and are skipped
				if (n > 0)
					n = $sscanf(line, "%d %d %h %h %h %h %h %d %h %h %h", test_num, op, addr,
						data, strb, exp_rdata, exp_resp, port_chk, exp_po, exp_pt, exp_irq);
				if (n == 11) begin
					if (test_num != cur_test) begin
						if (cur_test >= 0)
							close_test(cur_test);
						cur_test = test_num;
					end
					run_step(op, addr[7:0], data, strb[3:0], exp_rdata, exp_resp[1:0]);
					if (port_chk != 0 && !timed_out)
						check_pins(exp_po[7:0], exp_pt[7:0], exp_irq[0]);
				end
			end
			if (cur_test >= 0)
				close_test(cur_test);
			$fclose(fd);
		end

		$display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0 && tests_passed > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* gpio_input.txt */
# test op addr data strb exp_rdata exp_resp chk_pins exp_port_o exp_port_t exp_irq
# op 0 write, 1 read, 2 set port_i, 3 read until match; test, op, chk_pins decimal, rest hex
1 1 00 00000000 0 0000000F 0 1 A5 F0 0
1 1 08 00000000 0 000000A5 0 0 00 00 0
1 1 0C 00000000 0 00000000 0 0 00 00 0
1 1 10 00000000 0 00000000 0 1 A5 F0 0
2 0 00 000000FF F 00000000 0 1 A5 80 0
2 1 00 00000000 0 0000007F 0 1 A5 80 0
3 0 08 0000003C 0 00000000 0 1 A5 80 0
3 1 08 00000000 0 000000A5 0 0 00 00 0
3 0 08 0000003C 1 00000000 0 1 3C 80 0
3 0 08 0000C300 2 00000000 0 1 3C 80 0
3 1 08 00000000 0 0000003C 0 0 00 00 0
4 2 00 0000005A 0 00000000 0 0 00 00 0
4 3 04 00000000 0 0000005A 0 1 3C 80 0
4 2 00 00000000 0 00000000 0 0 00 00 0
4 3 04 00000000 0 00000000 0 0 00 00 0
4 0 10 000000FF 1 00000000 0 0 00 00 0
4 1 10 00000000 0 00000000 0 1 3C 80 0
5 0 0C 00000003 1 00000000 0 1 3C 80 0
5 2 00 00000083 0 00000000 0 0 00 00 0
5 3 10 00000000 0 00000083 0 1 3C 80 1
5 0 10 00000003 1 00000000 0 1 3C 80 0
5 1 10 00000000 0 00000080 0 1 3C 80 0
6 0 1C 12345678 F 00000000 2 0 00 00 0
6 1 1C 00000000 0 00000000 2 0 00 00 0
6 0 04 000000FF F 00000000 2 1 3C 80 0
6 1 04 00000000 0 00000083 0 1 3C 80 0
6 1 0C 00000000 0 00000003 0 0 00 00 0
6 1 08 00000000 0 0000003C 0 1 3C 80 0

/* compile.f */
gpio_bus_pkg.sv
gpio_reg_pkg.sv
gpio_if.sv
gpio_axil_decode.sv
gpio_port_exec.sv
gpio_axil_result.sv
gpio_subsystem.sv
gpio_tb_chk.sv
gpio_tb.sv

/* Bender.yml */
package:
  name: gpio_axil

sources:
  # packages first, then interfaces and RTL
  - gpio_bus_pkg.sv
  - gpio_reg_pkg.sv
  - gpio_if.sv
  - gpio_axil_decode.sv
  - gpio_port_exec.sv
  - gpio_axil_result.sv
  - gpio_subsystem.sv

  - target: test
    files:
      - gpio_tb_chk.sv
      - gpio_tb.sv
